// ==== vlog.f ====
+incdir+.
list_pkg.sv
tag_match.sv
lru_links.sv
line_state_table.sv
list_ctrl.sv
tb_list_ctrl.sv

// ==== tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int rsp_errors     = 0;
int state_errors   = 0;
int gnt_errors     = 0;
int timeout_errors = 0;

task automatic check_rsp(input string sig, input list_pkg::acc_rsp_t got,
                         input list_pkg::acc_rsp_t exp);
    if (got !== exp) begin
        rsp_errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
endtask

task automatic check_state(input string sig, input list_pkg::line_state_e got,
                           input list_pkg::line_state_e exp);
    if (got !== exp) begin
        state_errors++;
        $display("CHECK FAILED at %0t: %s got %s expected %s", $time, sig,
                 got.name(), exp.name());
    end
endtask

task automatic check_gnt(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
        gnt_errors++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, sig, got, exp);
    end
endtask

// no grant within the wait limit
task automatic report_timeout(input string what);
    timeout_errors++;
    $display("Timed out at %0t waiting for the grant on %s", $time, what);
endtask

function automatic int total_errors();
    return rsp_errors + state_errors + gnt_errors + timeout_errors;
endfunction

`endif

// ==== tb_list_ctrl.sv ====
`timescale 1ns/1ps

module tb_list_ctrl;

    localparam int CLK_PERIOD   = 20;
    localparam int GNT_TIMEOUT  = 20;
    localparam int STALL_CYCLES = 6;

    logic               clk;
    logic               rst_n;
    logic               acc_req;
    list_pkg::acc_req_t acc;
    logic               acc_gnt;
    list_pkg::acc_rsp_t rsp;

    integer seed = 99379;

    // reference model, lru_q[0] is the most recently used tag
    list_pkg::line_state_e m_state [list_pkg::LIST_DEPTH];
    list_pkg::index_t      m_index [list_pkg::LIST_DEPTH];
    list_pkg::tag_t        lru_q [$];
    int                    m_free;
    logic                  used_idx [1 << list_pkg::INDEX_W];

    `include "tb_checks.svh"

    list_ctrl dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .acc_req (acc_req),
        .acc     (acc),
        .acc_gnt (acc_gnt),
        .rsp     (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void model_reset();
        lru_q.delete();
        m_free = list_pkg::LIST_DEPTH;
        for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
            m_state[i] = list_pkg::st_invalid;
            m_index[i] = '0;
        end
        for (int i = 0; i < (1 << list_pkg::INDEX_W); i++) begin
            used_idx[i] = 1'b0;
        end
    endfunction

    // random tries first, then a sweep so it always ends
    function automatic list_pkg::index_t fresh_index();
        list_pkg::index_t cand;
        cand = list_pkg::index_t'($random(seed));
        for (int n = 0; n < 64 && used_idx[cand]; n++) begin
            cand = list_pkg::index_t'($random(seed));
        end
        for (int n = 0; n < (1 << list_pkg::INDEX_W) && used_idx[cand]; n++) begin
            cand = cand + 1'b1;
        end
        used_idx[cand] = 1'b1;
        return cand;
    endfunction

    function automatic list_pkg::acc_req_t make_req(input list_pkg::acc_cmd_e cmd,
                                                    input list_pkg::index_t idx,
                                                    input list_pkg::tag_t ftag);
        list_pkg::acc_req_t req;
        req.cmd   = cmd;
        req.index = idx;
        req.tag   = ftag;
        return req;
    endfunction

    function automatic list_pkg::acc_rsp_t make_rsp(input list_pkg::line_state_e s,
                                                    input list_pkg::index_t idx,
                                                    input list_pkg::tag_t t);
        list_pkg::acc_rsp_t r;
        r.state = s;
        r.index = idx;
        r.tag   = t;
        return r;
    endfunction

    // highest numbered live entry wins
    function automatic logic model_hit(input list_pkg::index_t idx, output list_pkg::tag_t t);
        logic hit;
        hit = 1'b0;
        t   = '0;
        for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
            if (m_state[i] != list_pkg::st_invalid && m_index[i] == idx) begin
                hit = 1'b1;
                t   = list_pkg::tag_t'(i);
            end
        end
        return hit;
    endfunction

    function automatic list_pkg::tag_t victim_tag();
        if (m_free > 0) begin
            return list_pkg::tag_t'(m_free - 1);
        end
        return lru_q[$];
    endfunction

    function automatic void move_to_head(input list_pkg::tag_t t);
        int pos = -1;
        for (int i = 0; i < lru_q.size(); i++) begin
            if (lru_q[i] == t) begin
                pos = i;
            end
        end
        if (pos >= 0) begin
            lru_q.delete(pos);
        end
        lru_q.push_front(t);
    endfunction

    function automatic void predict(input list_pkg::acc_req_t req, output logic gnt,
                                    output list_pkg::acc_rsp_t exp);
        list_pkg::tag_t t;
        list_pkg::tag_t v;
        logic           hit;
        hit = 1'b0;
        gnt = 1'b1;
        exp = '0;
        v   = victim_tag();
        if (req.cmd inside {list_pkg::cmd_read, list_pkg::cmd_write}) begin
            hit = model_hit(req.index, t);
        end
        if (hit) begin
            exp = make_rsp(m_state[t], m_index[t], t);
            gnt = !(req.cmd == list_pkg::cmd_write && m_state[t] == list_pkg::st_evict);
        end else if (req.cmd == list_pkg::cmd_alloc) begin
            exp = make_rsp(m_state[v], m_index[v], v);
            gnt = !(m_free == 0 && m_state[v] inside {list_pkg::st_fetch, list_pkg::st_evict});
        end
    endfunction

    function automatic void model_update(input list_pkg::acc_req_t req);
        list_pkg::tag_t t;
        t = req.tag;
        if (req.cmd == list_pkg::cmd_alloc) begin
            t = victim_tag();
            if (m_free > 0) begin
                m_free--;
            end
            move_to_head(t);
            if (m_state[t] == list_pkg::st_dirty) begin
                m_state[t] = list_pkg::st_evict;
            end else begin
                m_state[t] = list_pkg::st_fetch;
                m_index[t] = req.index;
            end
        end else if (req.cmd == list_pkg::cmd_fill) begin
            if (m_state[t] == list_pkg::st_fetch) begin
                m_state[t] = list_pkg::st_valid;
            end else if (m_state[t] == list_pkg::st_evict) begin
                m_state[t] = list_pkg::st_fetch;
                m_index[t] = req.index;
            end
        end else if (model_hit(req.index, t)) begin
            move_to_head(t);
            if (req.cmd == list_pkg::cmd_write && m_state[t] == list_pkg::st_valid) begin
                m_state[t] = list_pkg::st_dirty;
            end
        end
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n   = 1'b0;
        acc_req = 1'b0;
        acc     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        model_reset();
    endtask

    // rsp is sampled a quarter period after the falling edge
    task automatic send(input list_pkg::acc_req_t req, output logic ok,
                        output list_pkg::acc_rsp_t got);
        int waited = 0;
        ok  = 1'b0;
        got = '0;
        @(negedge clk);
        acc_req = 1'b1;
        acc     = req;
        #(CLK_PERIOD / 4);
        while (!acc_gnt && waited < GNT_TIMEOUT) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            waited++;
        end
        if (acc_gnt) begin
            ok  = 1'b1;
            got = rsp;
            @(posedge clk);
        end else begin
            report_timeout(req.cmd.name());
        end
        @(negedge clk);
        acc_req = 1'b0;
    endtask

    task automatic expect_stall(input list_pkg::acc_req_t req);
        @(negedge clk);
        acc_req = 1'b1;
        acc     = req;
        for (int n = 0; n < STALL_CYCLES; n++) begin
            #(CLK_PERIOD / 4);
            check_gnt("acc_gnt", acc_gnt, 1'b0);
            @(negedge clk);
        end
        acc_req = 1'b0;
    endtask

    task automatic do_cmd(input list_pkg::acc_cmd_e cmd, input list_pkg::index_t idx,
                          input list_pkg::tag_t ftag, output list_pkg::acc_rsp_t got);
        list_pkg::acc_req_t req;
        list_pkg::acc_rsp_t exp;
        logic               exp_gnt;
        logic               ok;
        req = make_req(cmd, idx, ftag);
        got = '0;
        predict(req, exp_gnt, exp);
        if (!exp_gnt) begin
            expect_stall(req);
        end else begin
            send(req, ok, got);
            if (ok) begin
                check_rsp("rsp", got, exp);
                model_update(req);
            end
        end
    endtask

    task automatic fill_all();
        list_pkg::acc_rsp_t r;
        for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
            do_cmd(list_pkg::cmd_alloc, fresh_index(), '0, r);
            do_cmd(list_pkg::cmd_fill, m_index[lru_q[0]], lru_q[0], r);
        end
    endtask

    // read whatever sits at the tail until t gets there
    task automatic rotate_to_tail(input list_pkg::tag_t t);
        list_pkg::acc_rsp_t r;
        for (int n = 0; n < list_pkg::LIST_DEPTH && lru_q[$] != t; n++) begin
            do_cmd(list_pkg::cmd_read, m_index[lru_q[$]], '0, r);
        end
    endtask

    task automatic test_alloc_order();
        list_pkg::acc_rsp_t r;
        apply_reset();
        for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
            do_cmd(list_pkg::cmd_alloc, fresh_index(), '0, r);
            check_rsp("rsp", r, make_rsp(list_pkg::st_invalid, '0,
                      list_pkg::tag_t'(list_pkg::LIST_DEPTH - 1 - i)));
        end
        for (int t = 0; t < list_pkg::LIST_DEPTH; t++) begin
            do_cmd(list_pkg::cmd_read, m_index[t], '0, r);
            check_state("rsp.state", r.state, list_pkg::st_fetch);
        end
    endtask

    task automatic test_fill_and_write();
        list_pkg::acc_rsp_t r;
        for (int t = 0; t < list_pkg::LIST_DEPTH; t++) begin
            do_cmd(list_pkg::cmd_fill, m_index[t], list_pkg::tag_t'(t), r);
        end
        for (int t = 0; t < list_pkg::LIST_DEPTH; t++) begin
            do_cmd(list_pkg::cmd_read, m_index[t], '0, r);
            check_state("rsp.state", r.state, list_pkg::st_valid);
        end
        do_cmd(list_pkg::cmd_write, m_index[0], '0, r);
        check_state("rsp.state", r.state, list_pkg::st_valid);
        do_cmd(list_pkg::cmd_read, m_index[0], '0, r);
        check_state("rsp.state", r.state, list_pkg::st_dirty);
    endtask

    task automatic test_lru_order();
        list_pkg::acc_rsp_t r;
        list_pkg::tag_t     order [$];
        list_pkg::tag_t     v;
        list_pkg::acc_rsp_t exp;
        apply_reset();
        fill_all();
        order = lru_q;
        foreach (order[i]) begin
            do_cmd(list_pkg::cmd_read, m_index[order[i]], '0, r);
        end
        for (int round = 0; round < 2; round++) begin
            v   = lru_q[$];
            exp = make_rsp(list_pkg::st_valid, m_index[v], v);
            do_cmd(list_pkg::cmd_alloc, fresh_index(), '0, r);
            check_rsp("rsp", r, exp);
            do_cmd(list_pkg::cmd_fill, m_index[v], v, r);
            do_cmd(list_pkg::cmd_read, m_index[lru_q[$]], '0, r);
            do_cmd(list_pkg::cmd_read, m_index[lru_q[2]], '0, r);
        end
    endtask

    task automatic test_busy_victim();
        list_pkg::acc_rsp_t r;
        list_pkg::tag_t     v;
        list_pkg::index_t   idx;
        apply_reset();
        fill_all();
        v = lru_q[$];
        do_cmd(list_pkg::cmd_alloc, fresh_index(), '0, r);
        rotate_to_tail(v);
        idx = fresh_index();
        expect_stall(make_req(list_pkg::cmd_alloc, idx, '0));
        do_cmd(list_pkg::cmd_fill, m_index[v], v, r);
        // victim must still be v, now valid, with the index it had
        do_cmd(list_pkg::cmd_alloc, idx, '0, r);
        check_state("rsp.state", r.state, list_pkg::st_valid);
    endtask

    task automatic test_dirty_victim();
        list_pkg::acc_rsp_t r;
        list_pkg::tag_t     v;
        list_pkg::index_t   old_idx;
        list_pkg::index_t   idx;
        apply_reset();
        fill_all();
        v       = lru_q[$];
        old_idx = m_index[v];
        do_cmd(list_pkg::cmd_write, old_idx, '0, r);
        rotate_to_tail(v);
        idx = fresh_index();
        do_cmd(list_pkg::cmd_alloc, idx, '0, r);
        check_rsp("rsp", r, make_rsp(list_pkg::st_dirty, old_idx, v));
        expect_stall(make_req(list_pkg::cmd_write, old_idx, '0));
        do_cmd(list_pkg::cmd_fill, idx, v, r);
        do_cmd(list_pkg::cmd_read, idx, '0, r);
        check_rsp("rsp", r, make_rsp(list_pkg::st_fetch, idx, v));
        do_cmd(list_pkg::cmd_fill, idx, v, r);
        do_cmd(list_pkg::cmd_read, idx, '0, r);
        check_state("rsp.state", r.state, list_pkg::st_valid);
    endtask

    task automatic test_misses();
        list_pkg::acc_rsp_t r;
        list_pkg::index_t   keep;
        apply_reset();
        fill_all();
        do_cmd(list_pkg::cmd_read, fresh_index(), '0, r);
        check_rsp("rsp", r, '0);
        keep = m_index[0];
        do_cmd(list_pkg::cmd_fill, fresh_index(), '0, r);
        do_cmd(list_pkg::cmd_read, keep, '0, r);
        check_rsp("rsp", r, make_rsp(list_pkg::st_valid, keep, '0));
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        acc_req = 1'b0;
        acc     = '0;
        model_reset();
        test_alloc_order();
        test_fill_and_write();
        test_lru_order();
        test_busy_victim();
        test_dirty_victim();
        test_misses();
        $display("errors: rsp %0d, state %0d, gnt %0d, timeout %0d",
                 rsp_errors, state_errors, gnt_errors, timeout_errors);
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list_ctrl.sv ====
`timescale 1ns/1ps

module list_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               acc_req,
    input  list_pkg::acc_req_t acc,
    output logic               acc_gnt,
    output list_pkg::acc_rsp_t rsp
);

    list_pkg::list_op_t    op;
    list_pkg::line_entry_t entries [list_pkg::LIST_DEPTH];
    list_pkg::tag_t        alloc_tag;
    logic                  free_avail;

    // request decode and response
    tag_match u_match (
        .acc_req    (acc_req),
        .acc        (acc),
        .entries    (entries),
        .alloc_tag  (alloc_tag),
        .free_avail (free_avail),
        .acc_gnt    (acc_gnt),
        .op         (op),
        .rsp        (rsp)
    );

    // replacement order
    lru_links u_links (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .alloc_tag  (alloc_tag),
        .free_avail (free_avail)
    );

    line_state_table u_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .acc_req (acc_req),
        .acc     (acc),
        .op      (op),
        .entries (entries)
    );

endmodule

// ==== line_state_table.sv ====
`timescale 1ns/1ps

module line_state_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_req,
    input  list_pkg::acc_req_t    acc,
    input  list_pkg::list_op_t    op,
    output list_pkg::line_entry_t entries [list_pkg::LIST_DEPTH]
);

    logic fill_req;
    logic write_touch;

    // fills are never held off, a request is an accepted fill
    assign fill_req    = acc_req && (acc.cmd == list_pkg::cmd_fill);
    assign write_touch = op.touch && (acc.cmd == list_pkg::cmd_write);

    for (genvar i = 0; i < list_pkg::LIST_DEPTH; i++) begin : g_entry
        list_pkg::line_entry_t nxt_entry;
        logic                  sel_alloc;
        logic                  sel_write;
        logic                  sel_fill;

        assign sel_alloc = op.alloc && (op.tag == list_pkg::tag_t'(i));
        assign sel_write = write_touch && (op.tag == list_pkg::tag_t'(i));
        assign sel_fill  = fill_req && (acc.tag == list_pkg::tag_t'(i));

        always_comb begin
            nxt_entry = entries[i];
            case (entries[i].state)
                list_pkg::st_invalid: begin
                    if (sel_alloc) begin
                        nxt_entry.state = list_pkg::st_fetch;
                        nxt_entry.index = acc.index;
                    end
                end
                list_pkg::st_valid: begin
                    if (sel_alloc) begin
                        nxt_entry.state = list_pkg::st_fetch;
                        nxt_entry.index = acc.index;
                    end else if (sel_write) begin
                        nxt_entry.state = list_pkg::st_dirty;
                    end
                end
                // old index stays until the writeback is done
                list_pkg::st_dirty: begin
                    if (sel_alloc) begin
                        nxt_entry.state = list_pkg::st_evict;
                    end
                end
                list_pkg::st_fetch: begin
                    if (sel_fill) begin
                        nxt_entry.state = list_pkg::st_valid;
                    end
                end
                list_pkg::st_evict: begin
                    if (sel_fill) begin
                        nxt_entry.state = list_pkg::st_fetch;
                        nxt_entry.index = acc.index;
                    end
                end
                default: begin
                    nxt_entry = entries[i];
                end
            endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                entries[i].state <= list_pkg::st_invalid;
                entries[i].index <= '0;
            end else begin
                entries[i] <= nxt_entry;
            end
        end

        // grant logic must keep busy lines out of replacement
        a_alloc_idle: assert property (
            @(posedge clk) disable iff (!rst_n)
            sel_alloc |-> !(entries[i].state inside {list_pkg::st_fetch, list_pkg::st_evict})
        ) else $error("allocation hit a line with an open transaction");

        a_state_legal: assert property (
            @(posedge clk) disable iff (!rst_n)
            entries[i].state inside {list_pkg::st_invalid, list_pkg::st_valid,
                list_pkg::st_dirty, list_pkg::st_fetch, list_pkg::st_evict}
        ) else $error("illegal line state");
    end

endmodule

// ==== lru_links.sv ====
`timescale 1ns/1ps

module lru_links (
    input  logic               clk,
    input  logic               rst_n,
    input  list_pkg::list_op_t op,
    output list_pkg::tag_t     alloc_tag,
    output logic               free_avail
);

    // list is kept as a ring, tail links forward to head
    list_pkg::tag_t   nxt_tag [list_pkg::LIST_DEPTH];
    list_pkg::tag_t   pre_tag [list_pkg::LIST_DEPTH];
    list_pkg::tag_t   head;
    list_pkg::tag_t   tail;
    list_pkg::count_t length;
    list_pkg::count_t free_cnt;
    logic             list_empty;
    logic             is_head;
    logic             is_tail;

    assign free_avail = free_cnt != '0;
    // free tags go out from the top down
    assign alloc_tag  = free_avail ? list_pkg::tag_t'(free_cnt - 1'b1) : tail;
    assign list_empty = length == '0;
    assign is_head    = op.tag == head;
    assign is_tail    = op.tag == tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            length   <= '0;
            free_cnt <= list_pkg::count_t'(list_pkg::LIST_DEPTH);
            for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
                nxt_tag[i] <= list_pkg::tag_t'(i);
                pre_tag[i] <= list_pkg::tag_t'(i);
            end
        end else if (op.alloc && free_avail) begin
            free_cnt <= free_cnt - 1'b1;
            length   <= length + 1'b1;
            head     <= op.tag;
            if (list_empty) begin
                // single member rings onto itself
                tail             <= op.tag;
                nxt_tag[op.tag]  <= op.tag;
                pre_tag[op.tag]  <= op.tag;
            end else begin
                nxt_tag[op.tag] <= head;
                pre_tag[op.tag] <= tail;
                pre_tag[head]   <= op.tag;
                nxt_tag[tail]   <= op.tag;
            end
        end else if (op.alloc) begin
            // full, the victim is the tail so the ring just rotates
            head <= op.tag;
            tail <= pre_tag[op.tag];
        end else if (op.touch && !is_head) begin
            head <= op.tag;
            if (is_tail) begin
                tail <= pre_tag[op.tag];
            end else begin
                // unlink from the middle
                nxt_tag[pre_tag[op.tag]] <= nxt_tag[op.tag];
                pre_tag[nxt_tag[op.tag]] <= pre_tag[op.tag];
                // and close it in between tail and head
                nxt_tag[op.tag] <= head;
                pre_tag[op.tag] <= tail;
                pre_tag[head]   <= op.tag;
                nxt_tag[tail]   <= op.tag;
            end
        end
    end

    a_len_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        length <= list_pkg::LIST_DEPTH
    ) else $error("lru list longer than LIST_DEPTH");

    // touch and alloc come from one decoded command
    a_one_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(op.touch && op.alloc)
    ) else $error("touch and alloc in the same cycle");

    // a full list must be a closed ring for the tail rotation to work
    a_ring_closed: assert property (
        @(posedge clk) disable iff (!rst_n)
        (length == list_pkg::LIST_DEPTH) |-> (pre_tag[head] == tail)
    ) else $error("head does not link back to tail on a full list");

endmodule

// ==== tag_match.sv ====
`timescale 1ns/1ps

module tag_match (
    input  logic                  acc_req,
    input  list_pkg::acc_req_t    acc,
    input  list_pkg::line_entry_t entries [list_pkg::LIST_DEPTH],
    input  list_pkg::tag_t        alloc_tag,
    input  logic                  free_avail,
    output logic                  acc_gnt,
    output list_pkg::list_op_t    op,
    output list_pkg::acc_rsp_t    rsp
);

    logic           lookup;
    logic           is_alloc;
    logic           hit;
    list_pkg::tag_t hit_tag;
    logic           victim_busy;
    logic           write_blocked;
    logic           accept;

    assign lookup   = (acc.cmd == list_pkg::cmd_write) || (acc.cmd == list_pkg::cmd_read);
    assign is_alloc = acc.cmd == list_pkg::cmd_alloc;

    // highest matching tag wins
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < list_pkg::LIST_DEPTH; i++) begin
            if (lookup && entries[i].state != list_pkg::st_invalid &&
                    entries[i].index == acc.index) begin
                hit     = 1'b1;
                hit_tag = list_pkg::tag_t'(i);
            end
        end
    end

    // replacing the lru tail has to wait for its fetch or writeback
    assign victim_busy = !free_avail &&
        (entries[alloc_tag].state == list_pkg::st_fetch ||
         entries[alloc_tag].state == list_pkg::st_evict);

    // no writes into a line whose old data is still leaving
    assign write_blocked = (acc.cmd == list_pkg::cmd_write) && hit &&
        (entries[hit_tag].state == list_pkg::st_evict);

    assign acc_gnt = !((is_alloc && victim_busy) || write_blocked);
    assign accept  = acc_req && acc_gnt;

    always_comb begin
        op.touch = accept && hit;
        op.alloc = accept && is_alloc;
        op.tag   = is_alloc ? alloc_tag : hit_tag;
    end

    // allocation reports the victim as it was, old index is the writeback address
    always_comb begin
        rsp = '0;
        if (hit) begin
            rsp.state = entries[hit_tag].state;
            rsp.index = entries[hit_tag].index;
            rsp.tag   = hit_tag;
        end else if (op.alloc) begin
            rsp.state = entries[alloc_tag].state;
            rsp.index = entries[alloc_tag].index;
            rsp.tag   = alloc_tag;
        end
    end

endmodule

// ==== list_pkg.sv ====
package list_pkg;

    localparam int LIST_DEPTH = 4;
    localparam int TAG_W      = $clog2(LIST_DEPTH);
    localparam int INDEX_W    = 4;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W:0]     count_t;

    // bit 2 set while a memory transaction is open on the line
    typedef enum logic [2:0] {
        st_invalid = 3'b000,
        st_valid   = 3'b001,
        st_dirty   = 3'b010,
        st_fetch   = 3'b100,
        st_evict   = 3'b110
    } line_state_e;

    typedef enum logic [1:0] {
        cmd_write = 2'b00,
        cmd_read  = 2'b01,
        cmd_alloc = 2'b10,
        cmd_fill  = 2'b11
    } acc_cmd_e;

    // tag is only looked at for a fill
    typedef struct packed {
        acc_cmd_e cmd;
        index_t   index;
        tag_t     tag;
    } acc_req_t;

    typedef struct packed {
        line_state_e state;
        index_t      index;
        tag_t        tag;
    } acc_rsp_t;

    typedef struct packed {
        line_state_e state;
        index_t      index;
    } line_entry_t;

    typedef struct packed {
        logic touch;
        logic alloc;
        tag_t tag;
    } list_op_t;

endpackage
